/* sources.f */
+incdir+verification
verilog/dcache_pkg.sv
verilog/dcache_if.sv
verilog/dcache_req_buf.sv
verilog/dcache_tagv_array.sv
verilog/dcache_data_array.sv
verilog/dcache_lru.sv
verilog/dcache_ctrl.sv
verilog/dcache_top.sv
verification/tb_dcache.sv

/* verification/tb_dcache_model.svh */
// reference model of the memory and of the cache state

localparam int tag_w    = 32 - idx_w - dcache_pkg::offset_width;
localparam int num_sets = 1 << idx_w;

dcache_pkg::word_t mem_image [dcache_pkg::addr_t];
logic [tag_w-1:0]  model_tag [2][num_sets];
logic              model_valid [2][num_sets];
// least recently used way per set
logic              model_lru [num_sets];
logic [31:0]       rng_state;

function automatic void model_reset();
    rng_state = 32'h2c18;
    for (int s = 0; s < num_sets; s++) begin
        model_valid[0][s] = 1'b0;
        model_valid[1][s] = 1'b0;
        model_lru[s]      = 1'b0;
    end
endfunction

function automatic logic [31:0] xorshift32();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
endfunction

function automatic dcache_pkg::addr_t addr_of(input int tag, input int set);
    return {tag[tag_w-1:0], set[idx_w-1:0], 2'b00};
endfunction

function automatic dcache_pkg::word_t mem_word(input dcache_pkg::addr_t a);
    dcache_pkg::addr_t wa;
    wa = {a[31:2], 2'b00};
    if (mem_image.exists(wa)) begin
        return mem_image[wa];
    end
    // untouched words read as a pattern of their whole address
    return {wa[15:0], wa[31:16]} ^ wa ^ 32'h3c5a_96e1;
endfunction

function automatic void mem_write(input dcache_pkg::addr_t a, input dcache_pkg::wstrb_t s,
                                  input dcache_pkg::word_t d);
    dcache_pkg::word_t w;
    w = mem_word(a);
    for (int b = 0; b < 4; b++) begin
        if (s[b]) begin
            w[8*b +: 8] = d[8*b +: 8];
        end
    end
    mem_image[{a[31:2], 2'b00}] = w;
endfunction

// way holding the address, -1 when absent
function automatic int find_way(input dcache_pkg::addr_t a);
    int s;
    s = a[2 +: idx_w];
    for (int w = 0; w < 2; w++) begin
        if (model_valid[w][s] && model_tag[w][s] == a[31 -: tag_w]) begin
            return w;
        end
    end
    return -1;
endfunction

// expected read data, whether memory gets read, and the state change
function automatic dcache_pkg::word_t ref_read(input dcache_pkg::addr_t a, input logic suc,
                                               output logic miss);
    int s;
    int hw;
    int v;
    s    = a[2 +: idx_w];
    hw   = find_way(a);
    miss = suc || hw < 0;
    if (suc) begin
        if (hw >= 0) model_valid[hw][s] = 1'b0;
    end else if (hw >= 0) begin
        model_lru[s] = (hw == 0);
    end else begin
        v = model_lru[s];
        model_valid[v][s] = 1'b1;
        model_tag[v][s]   = a[31 -: tag_w];
        model_lru[s]      = (v == 0);
    end
    return mem_word(a);
endfunction

// write through, no allocation on a miss
function automatic void ref_write(input dcache_pkg::addr_t a, input logic suc);
    int hw;
    hw = find_way(a);
    if (hw >= 0) begin
        if (suc) model_valid[hw][a[2 +: idx_w]] = 1'b0;
        else model_lru[a[2 +: idx_w]] = (hw == 0);
    end
endfunction

function automatic void ref_op(input dcache_pkg::cache_op_t code, input dcache_pkg::addr_t a);
    int hw;
    hw = find_way(a);
    // index ops pick the way with address bit 0
    if (code == dcache_pkg::op_index_init || code == dcache_pkg::op_index_inv) begin
        model_valid[a[0]][a[2 +: idx_w]] = 1'b0;
    end else if (code == dcache_pkg::op_hit_inv && hw >= 0) begin
        model_valid[hw][a[2 +: idx_w]] = 1'b0;
    end
endfunction

/* verification/tb_dcache.sv */
`timescale 1ns/10ps

module tb_dcache;

    localparam int idx_w         = 4;
    localparam int num_tests     = 6;
    localparam int reqs_per_test = 40;
    localparam int max_cycles    = num_tests * reqs_per_test * 10;

    logic                  clk;
    logic                  rstn;
    logic                  req_valid;
    logic                  req_op;
    logic                  req_wr;
    logic                  req_suc;
    dcache_pkg::cache_op_t req_opcode;
    dcache_pkg::addr_t     req_addr;
    dcache_pkg::wstrb_t    req_wstrb;
    dcache_pkg::word_t     req_wdata;
    logic                  req_ready;
    logic                  resp_valid;
    dcache_pkg::word_t     resp_rdata;
    logic                  op_ack;
    logic                  mem_req;
    logic                  mem_wr;
    dcache_pkg::addr_t     mem_addr;
    dcache_pkg::wstrb_t    mem_wstrb;
    dcache_pkg::word_t     mem_wdata;
    logic                  mem_addr_ok;
    logic                  mem_data_ok;
    dcache_pkg::word_t     mem_rdata;

    string cur_test;
    int    errors;
    int    errors_at_start;
    int    tests_run;
    int    tests_failed;
    int    mem_reads;
    int    mem_writes;
    int    resp_count;
    int    ack_count;
    int    reads_issued;
    int    ops_issued;
    int    cycles;
    logic  read_pending;

    // expected read data and bus writes in issue order
    dcache_pkg::word_t  exp_rdata [$];
    dcache_pkg::addr_t  exp_wr_addr [$];
    dcache_pkg::wstrb_t exp_wr_strb [$];
    dcache_pkg::word_t  exp_wr_data [$];

    `include "tb_dcache_model.svh"

    dcache_top #(.index_width(idx_w)) u_dcache_top (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin : watchdog
        cycles = 0;
        while (cycles < max_cycles) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout, requests did not complete within %0d cycles", max_cycles);
        $display("TEST FAILED");
        $finish;
    end

    ////////////////////
    // memory with random accept and return delays
    initial begin : memory_responder
        logic              addr_armed;
        int                addr_wait;
        int                data_wait;
        dcache_pkg::addr_t rd_addr;
        addr_armed   = 1'b0;
        read_pending = 1'b0;
        forever begin
            @(posedge clk);
            if (mem_data_ok) read_pending = 1'b0;
            if (rstn && mem_req && mem_addr_ok) begin
                addr_armed = 1'b0;
                if (mem_wr) begin
                    if (exp_wr_addr.size() == 0) begin
                        $display("%s: memory write with no write request issued", cur_test);
                        errors++;
                    end else if (mem_addr != exp_wr_addr[0] || mem_wstrb != exp_wr_strb[0] ||
                                 mem_wdata != exp_wr_data[0]) begin
                        $display("ERROR %s: write expected %h/%h/%h actual %h/%h/%h", cur_test,
                                 exp_wr_addr[0], exp_wr_strb[0], exp_wr_data[0],
                                 mem_addr, mem_wstrb, mem_wdata);
                        errors++;
                    end
                    if (exp_wr_addr.size() != 0) begin
                        void'(exp_wr_addr.pop_front());
                        void'(exp_wr_strb.pop_front());
                        void'(exp_wr_data.pop_front());
                    end
                    mem_write(mem_addr, mem_wstrb, mem_wdata);
                    mem_writes++;
                end else begin
                    read_pending = 1'b1;
                    rd_addr      = mem_addr;
                    data_wait    = xorshift32() % 4;
                    mem_reads++;
                end
            end
            #1;
            mem_addr_ok = 1'b0;
            mem_data_ok = 1'b0;
            if (rstn && mem_req && !read_pending) begin
                if (!addr_armed) begin
                    addr_armed = 1'b1;
                    addr_wait  = xorshift32() % 4;
                end else begin
                    addr_wait--;
                end
                mem_addr_ok = (addr_wait == 0);
            end
            if (read_pending) begin
                if (data_wait == 0) begin
                    mem_data_ok = 1'b1;
                    mem_rdata   = mem_word(rd_addr);
                end else begin
                    data_wait--;
                end
            end
        end
    end

    ////////////////////
    // response compare
    always @(posedge clk) begin : compare_resp
        dcache_pkg::word_t expected;
        if (rstn && resp_valid) begin
            resp_count++;
            if (exp_rdata.size() == 0) begin
                $display("%s: response without an outstanding read", cur_test);
                errors++;
            end else begin
                expected = exp_rdata.pop_front();
                if (resp_rdata !== expected) begin
                    $display("ERROR %s: rdata expected %h actual %h", cur_test, expected,
                             resp_rdata);
                    errors++;
                end
            end
        end
        if (rstn && op_ack) ack_count++;
    end

    // back-pressure while the bus holds a request
    always @(negedge clk) begin
        if (rstn && req_ready &&
            ((mem_req && !mem_addr_ok) || (read_pending && !mem_data_ok))) begin
            $display("%s: req_ready was high while a memory request was pending", cur_test);
            errors++;
        end
    end

    task automatic send_req(input logic op, input logic wr, input logic suc,
                            input dcache_pkg::cache_op_t code, input dcache_pkg::addr_t a,
                            input dcache_pkg::wstrb_t s, input dcache_pkg::word_t d);
        @(posedge clk);
        #1;
        req_valid  = 1'b1;
        req_op     = op;
        req_wr     = wr;
        req_suc    = suc;
        req_opcode = code;
        req_addr   = a;
        req_wstrb  = s;
        req_wdata  = d;
        do @(posedge clk); while (!req_ready);
        #1;
        req_valid = 1'b0;
    endtask

    task automatic do_read(input dcache_pkg::addr_t a, input logic suc);
        logic exp_miss;
        int   reads_before;
        int   target;
        exp_rdata.push_back(ref_read(a, suc, exp_miss));
        reads_issued++;
        reads_before = mem_reads;
        target       = resp_count + 1;
        send_req(1'b0, 1'b0, suc, '0, a, '0, '0);
        while (resp_count < target) @(negedge clk);
        if (mem_reads - reads_before != int'(exp_miss)) begin
            $display("ERROR %s: memory reads for %h expected %0d actual %0d", cur_test, a,
                     int'(exp_miss), mem_reads - reads_before);
            errors++;
        end
    endtask

    task automatic do_write(input dcache_pkg::addr_t a, input dcache_pkg::wstrb_t s,
                            input dcache_pkg::word_t d, input logic suc);
        int target;
        ref_write(a, suc);
        exp_wr_addr.push_back(a);
        exp_wr_strb.push_back(s);
        exp_wr_data.push_back(d);
        target = mem_writes + 1;
        send_req(1'b0, 1'b1, suc, '0, a, s, d);
        while (mem_writes < target) @(negedge clk);
    endtask

    task automatic do_op(input dcache_pkg::cache_op_t code, input dcache_pkg::addr_t a);
        int target;
        ref_op(code, a);
        ops_issued++;
        target = ack_count + 1;
        send_req(1'b1, 1'b0, 1'b0, code, a, '0, '0);
        while (ack_count < target) @(negedge clk);
    endtask

    task automatic begin_test(input string name);
        cur_test        = name;
        errors_at_start = errors;
    endtask

    task automatic finish_test();
        tests_run++;
        if (errors == errors_at_start) begin
            $display("%s: pass", cur_test);
        end else begin
            tests_failed++;
            $display("%s: fail, %0d errors", cur_test, errors - errors_at_start);
        end
    endtask

    ////////////////////
    initial begin : main_flow
        dcache_pkg::addr_t a;
        dcache_pkg::addr_t b;
        dcache_pkg::addr_t c;
        logic [31:0]       r;
        rstn = 1'b0;
        req_valid = 1'b0;
        req_op = 1'b0;
        req_wr = 1'b0;
        req_suc = 1'b0;
        req_opcode = '0;
        req_addr = '0;
        req_wstrb = '0;
        req_wdata = '0;
        mem_addr_ok = 1'b0;
        mem_data_ok = 1'b0;
        mem_rdata = '0;
        errors = 0;
        tests_run = 0;
        tests_failed = 0;
        mem_reads = 0;
        mem_writes = 0;
        resp_count = 0;
        ack_count = 0;
        reads_issued = 0;
        ops_issued = 0;
        cur_test = "reset";
        model_reset();
        repeat (5) @(posedge clk);
        #1;
        rstn = 1'b1;

        begin_test("read_miss");
        a = addr_of(26'h12, 3);
        do_read(a, 1'b0);
        do_read(a, 1'b0);
        finish_test();

        // a write hit merges bytes and a write miss leaves the cache alone
        begin_test("write_through");
        do_write(a, 4'b0101, 32'hdead_beef, 1'b0);
        do_read(a, 1'b0);
        b = addr_of(26'h40, 5);
        do_write(b, 4'b1100, 32'h1234_5678, 1'b0);
        do_read(b, 1'b0);
        finish_test();

        begin_test("lru_victim");
        a = addr_of(1, 7);
        b = addr_of(2, 7);
        c = addr_of(3, 7);
        do_read(a, 1'b0);
        do_read(b, 1'b0);
        do_read(a, 1'b0);
        do_read(c, 1'b0);
        do_read(b, 1'b0);
        do_read(c, 1'b0);
        do_read(a, 1'b0);
        finish_test();

        begin_test("uncached_read");
        c = addr_of(5, 9);
        do_read(c, 1'b0);
        do_read(c, 1'b1);
        do_read(c, 1'b0);
        do_read(c, 1'b1);
        do_read(c, 1'b0);
        finish_test();

        begin_test("cache_ops");
        a = addr_of(6, 11);
        b = addr_of(7, 11);
        do_read(a, 1'b0);
        do_read(b, 1'b0);
        do_op(dcache_pkg::op_hit_inv, a);
        do_read(b, 1'b0);
        do_read(a, 1'b0);
        do_op(dcache_pkg::op_index_inv, addr_of(0, 11) | 32'd1);
        do_read(b, 1'b0);
        do_op(dcache_pkg::op_index_init, addr_of(0, 11));
        do_read(b, 1'b0);
        do_read(a, 1'b0);
        finish_test();

        // small address pool so hits, evictions and invalidations mix
        begin_test("random_delay");
        for (int i = 0; i < reqs_per_test; i++) begin
            r = xorshift32();
            a = addr_of(int'(r[9:8]), int'(r[11:10]));
            case (r[2:0])
                3'd4:       do_read(a, 1'b1);
                3'd5, 3'd6: do_write(a, r[15:12], xorshift32(), r[16]);
                3'd7:       do_op(dcache_pkg::cache_op_t'(r[20:19] % 3), a | r[17]);
                default:    do_read(a, 1'b0);
            endcase
        end
        if (resp_count != reads_issued) begin
            $display("%s: %0d responses came back for %0d reads", cur_test, resp_count,
                     reads_issued);
            errors++;
        end
        if (ack_count != ops_issued) begin
            $display("%s: %0d op acks came back for %0d cache ops", cur_test, ack_count,
                     ops_issued);
            errors++;
        end
        finish_test();

        $display("tests %0d, failed %0d, errors %0d, reads %0d, writes %0d, responses %0d",
                 tests_run, tests_failed, errors, mem_reads, mem_writes, resp_count);
        if (errors == 0 && tests_failed == 0) begin
            $display("TEST OK");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

/* verilog/dcache_top.sv */
`timescale 1ns/10ps

module dcache_top #(
    parameter int index_width = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    // pipeline side
    input  logic                  req_valid,
    input  logic                  req_op,
    input  logic                  req_wr,
    input  logic                  req_suc,
    input  dcache_pkg::cache_op_t req_opcode,
    input  dcache_pkg::addr_t     req_addr,
    input  dcache_pkg::wstrb_t    req_wstrb,
    input  dcache_pkg::word_t     req_wdata,
    output logic                  req_ready,
    output logic                  resp_valid,
    output dcache_pkg::word_t     resp_rdata,
    output logic                  op_ack,
    // memory side
    output logic                  mem_req,
    output logic                  mem_wr,
    output dcache_pkg::addr_t     mem_addr,
    output dcache_pkg::wstrb_t    mem_wstrb,
    output dcache_pkg::word_t     mem_wdata,
    input  logic                  mem_addr_ok,
    input  logic                  mem_data_ok,
    input  dcache_pkg::word_t     mem_rdata
);

    rbuf_if  rbuf ();
    array_if arr ();

    logic                   load;
    logic [index_width-1:0] lookup_index;

    // arrays see the new index in the accept cycle
    assign lookup_index = load ? req_addr[dcache_pkg::offset_width +: index_width]
                               : rbuf.addr[dcache_pkg::offset_width +: index_width];

    assign mem_addr  = rbuf.addr;
    assign mem_wstrb = rbuf.wstrb;
    assign mem_wdata = rbuf.wdata;

    dcache_req_buf #(.index_width(index_width)) u_req_buf (
        .clk(clk), .rstn(rstn),
        .req_op(req_op), .req_wr(req_wr), .req_suc(req_suc),
        .req_opcode(req_opcode), .req_addr(req_addr),
        .req_wstrb(req_wstrb), .req_wdata(req_wdata),
        .load(load), .rbuf(rbuf.source)
    );

    dcache_tagv_array #(.index_width(index_width)) u_tagv_array (
        .clk(clk), .rstn(rstn), .lookup_index(lookup_index),
        .rbuf(rbuf.sink), .arr(arr.array)
    );

    dcache_data_array #(.index_width(index_width)) u_data_array (
        .clk(clk), .lookup_index(lookup_index),
        .rbuf(rbuf.sink), .arr(arr.array),
        .mem_rdata(mem_rdata), .rdata(resp_rdata)
    );

    dcache_lru #(.index_width(index_width)) u_lru (
        .clk(clk), .rstn(rstn), .rbuf(rbuf.sink), .arr(arr.array)
    );

    dcache_ctrl u_ctrl (
        .clk(clk), .rstn(rstn),
        .req_valid(req_valid), .req_op(req_op), .req_ready(req_ready),
        .resp_valid(resp_valid), .op_ack(op_ack),
        .mem_req(mem_req), .mem_wr(mem_wr),
        .mem_addr_ok(mem_addr_ok), .mem_data_ok(mem_data_ok),
        .load(load), .rbuf(rbuf.sink), .arr(arr.ctrl)
    );

endmodule

/* verilog/dcache_ctrl.sv */
`timescale 1ns/10ps

module dcache_ctrl (
    input  logic  clk,
    input  logic  rstn,
    input  logic  req_valid,
    input  logic  req_op,
    output logic  req_ready,
    output logic  resp_valid,
    output logic  op_ack,
    output logic  mem_req,
    output logic  mem_wr,
    input  logic  mem_addr_ok,
    input  logic  mem_data_ok,
    output logic  load,
    rbuf_if.sink  rbuf,
    array_if.ctrl arr
);

    dcache_pkg::ctrl_state_t state;
    dcache_pkg::ctrl_state_t next_state;
    dcache_pkg::ctrl_state_t accept_state;
    dcache_pkg::way_vec_t    op_way;
    logic                    miss;

    // uncached access is handled as a miss
    assign miss   = ~|arr.hit || rbuf.suc;
    assign op_way = rbuf.addr[0] ? 2'b10 : 2'b01;
    assign load   = req_valid && req_ready;

    // next state whenever a new request can be taken
    assign accept_state = !req_valid ? dcache_pkg::st_idle :
                          req_op ? dcache_pkg::st_operation : dcache_pkg::st_lookup;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= dcache_pkg::st_idle;
        end else begin
            state <= next_state;
        end
    end

    ////////////////////
    // transitions
    always_comb begin
        next_state = state;
        case (state)
            dcache_pkg::st_idle:      next_state = accept_state;
            dcache_pkg::st_operation: next_state = accept_state;
            dcache_pkg::st_miss_done: next_state = accept_state;
            dcache_pkg::st_lookup: begin
                if (!rbuf.wr && !miss) begin
                    next_state = accept_state;
                end else if (!rbuf.wr) begin
                    next_state = mem_addr_ok ? dcache_pkg::st_miss_wait
                                             : dcache_pkg::st_miss_read;
                end else if (mem_addr_ok) begin
                    next_state = accept_state;
                end else begin
                    next_state = miss ? dcache_pkg::st_miss_write
                                      : dcache_pkg::st_hit_write;
                end
            end
            dcache_pkg::st_miss_read: begin
                if (mem_addr_ok) next_state = dcache_pkg::st_miss_wait;
            end
            dcache_pkg::st_miss_wait: begin
                if (mem_data_ok) next_state = dcache_pkg::st_miss_done;
            end
            dcache_pkg::st_miss_write,
            dcache_pkg::st_hit_write: begin
                if (mem_addr_ok) next_state = accept_state;
            end
            default: next_state = dcache_pkg::st_idle;
        endcase
    end

    ////////////////////
    // outputs and array commands
    always_comb begin
        req_ready         = 1'b0;
        resp_valid        = 1'b0;
        op_ack            = 1'b0;
        mem_req           = 1'b0;
        mem_wr            = 1'b0;
        arr.data_we       = '0;
        arr.tagv_unvalid  = '0;
        arr.tagv_init     = '0;
        arr.refill        = 1'b0;
        arr.choose_way    = 1'b0;
        arr.choose_return = 1'b0;
        arr.use0          = 1'b0;
        arr.use1          = 1'b0;
        case (state)
            dcache_pkg::st_idle: req_ready = 1'b1;
            dcache_pkg::st_lookup: begin
                // drop a cached copy of an uncached address
                if (rbuf.suc) arr.tagv_unvalid = arr.hit;
                if (rbuf.wr || miss) begin
                    mem_req = 1'b1;
                    mem_wr  = rbuf.wr;
                end
                if (!miss) begin
                    arr.use0 = arr.hit[0];
                    arr.use1 = arr.hit[1];
                    if (rbuf.wr) begin
                        arr.data_we = arr.hit;
                    end else begin
                        arr.choose_way = arr.hit[1];
                        resp_valid     = 1'b1;
                    end
                end
                req_ready = rbuf.wr ? mem_addr_ok : !miss;
            end
            dcache_pkg::st_operation: begin
                req_ready = 1'b1;
                op_ack    = 1'b1;
                case (rbuf.opcode)
                    dcache_pkg::op_index_init: arr.tagv_init    = op_way;
                    dcache_pkg::op_index_inv:  arr.tagv_unvalid = op_way;
                    dcache_pkg::op_hit_inv:    arr.tagv_unvalid = arr.hit;
                    default: ;
                endcase
            end
            dcache_pkg::st_miss_read: mem_req = 1'b1;
            dcache_pkg::st_miss_wait: begin
                if (mem_data_ok) begin
                    resp_valid        = 1'b1;
                    arr.choose_return = 1'b1;
                    arr.refill        = 1'b1;
                    // refill into the LRU way unless uncached
                    if (!rbuf.suc) begin
                        arr.data_we = arr.victim ? 2'b10 : 2'b01;
                        arr.use0    = !arr.victim;
                        arr.use1    = arr.victim;
                    end
                end
            end
            dcache_pkg::st_miss_done: req_ready = 1'b1;
            dcache_pkg::st_miss_write,
            dcache_pkg::st_hit_write: begin
                mem_req   = 1'b1;
                mem_wr    = 1'b1;
                req_ready = mem_addr_ok;
            end
            default: ;
        endcase
    end

    // bus request and its address hold until accepted
    assert property (@(posedge clk) disable iff (!rstn)
        mem_req && !mem_addr_ok |=> mem_req && $stable(rbuf.addr));

endmodule

/* verilog/dcache_lru.sv */
`timescale 1ns/10ps

module dcache_lru #(
    parameter int index_width = 4
) (
    input  logic   clk,
    input  logic   rstn,
    rbuf_if.sink   rbuf,
    array_if.array arr
);

    localparam int num_sets = 1 << index_width;

    // bit set means way 1 is the least recently used
    logic [num_sets-1:0]    lru_bits;
    logic [index_width-1:0] index;

    assign index = rbuf.addr[dcache_pkg::offset_width +: index_width];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            lru_bits <= '0;
        end else if (arr.use0) begin
            lru_bits[index] <= 1'b1;
        end else if (arr.use1) begin
            lru_bits[index] <= 1'b0;
        end
    end

    assign arr.victim = lru_bits[index];

endmodule

/* verilog/dcache_data_array.sv */
`timescale 1ns/10ps

module dcache_data_array #(
    parameter int index_width = 4
) (
    input  logic                   clk,
    input  logic [index_width-1:0] lookup_index,
    rbuf_if.sink                   rbuf,
    array_if.array                 arr,
    input  dcache_pkg::word_t      mem_rdata,
    output dcache_pkg::word_t      rdata
);

    localparam int num_sets = 1 << index_width;

    dcache_pkg::word_t      data_mem [2][num_sets];
    logic [index_width-1:0] rd_index;
    logic [index_width-1:0] wr_index;
    dcache_pkg::word_t      merged;

    assign wr_index = rbuf.addr[dcache_pkg::offset_width +: index_width];

    always_ff @(posedge clk) begin
        rd_index <= lookup_index;
    end

    ////////////////////
    // write hit: merge the strobed bytes into the stored word
    always_comb begin
        merged = data_mem[arr.data_we[1]][wr_index];
        for (int b = 0; b < 4; b++) begin
            if (rbuf.wstrb[b]) begin
                merged[8*b +: 8] = rbuf.wdata[8*b +: 8];
            end
        end
    end

    // refill takes the whole memory word
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (arr.data_we[w]) begin
                data_mem[w][wr_index] <= arr.refill ? mem_rdata : merged;
            end
        end
    end

    ////////////////////
    // read result, memory word bypasses the array on a miss return
    assign rdata = arr.choose_return ? mem_rdata : data_mem[arr.choose_way][rd_index];

endmodule

/* verilog/dcache_tagv_array.sv */
`timescale 1ns/10ps

module dcache_tagv_array #(
    parameter int index_width = 4
) (
    input  logic                   clk,
    input  logic                   rstn,
    input  logic [index_width-1:0] lookup_index,
    rbuf_if.sink                   rbuf,
    array_if.array                 arr
);

    localparam int tag_width = 32 - index_width - dcache_pkg::offset_width;
    localparam int num_sets  = 1 << index_width;

    logic [tag_width-1:0]   tag_mem [2][num_sets];
    dcache_pkg::way_vec_t   valid_mem [num_sets];
    logic [index_width-1:0] rd_index;
    logic [index_width-1:0] wr_index;
    logic [tag_width-1:0]   req_tag;
    dcache_pkg::way_vec_t   hit_vec;

    assign wr_index = rbuf.addr[dcache_pkg::offset_width +: index_width];
    assign req_tag  = rbuf.addr[31 -: tag_width];

    // registered read address
    always_ff @(posedge clk) begin
        rd_index <= lookup_index;
    end

    ////////////////////
    // valid bits
    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int s = 0; s < num_sets; s++) begin
                valid_mem[s] <= '0;
            end
        end else begin
            for (int w = 0; w < 2; w++) begin
                if (arr.data_we[w]) begin
                    valid_mem[wr_index][w] <= 1'b1;
                end else if (arr.tagv_unvalid[w] || arr.tagv_init[w]) begin
                    valid_mem[wr_index][w] <= 1'b0;
                end
            end
        end
    end

    // tags, init clears the tag too
    always_ff @(posedge clk) begin
        for (int w = 0; w < 2; w++) begin
            if (arr.data_we[w]) begin
                tag_mem[w][wr_index] <= req_tag;
            end else if (arr.tagv_init[w]) begin
                tag_mem[w][wr_index] <= '0;
            end
        end
    end

    ////////////////////
    // per-way compare against the buffered tag
    always_comb begin
        for (int w = 0; w < 2; w++) begin
            hit_vec[w] = valid_mem[rd_index][w] && (tag_mem[w][rd_index] == req_tag);
        end
    end

    assign arr.hit = hit_vec;

    // a line is never refilled into a set that already holds it
    assert property (@(posedge clk) disable iff (!rstn) !(arr.hit[0] && arr.hit[1]));

endmodule

/* verilog/dcache_req_buf.sv */
`timescale 1ns/10ps

module dcache_req_buf #(
    parameter int index_width = 4
) (
    input  logic                  clk,
    input  logic                  rstn,
    input  logic                  req_op,
    input  logic                  req_wr,
    input  logic                  req_suc,
    input  dcache_pkg::cache_op_t req_opcode,
    input  dcache_pkg::addr_t     req_addr,
    input  dcache_pkg::wstrb_t    req_wstrb,
    input  dcache_pkg::word_t     req_wdata,
    input  logic                  load,
    rbuf_if.source                rbuf
);

    // request kind and address
    // index field starts defined so the lookup index is known from reset
    always_ff @(posedge clk) begin
        if (!rstn) begin
            rbuf.op  <= 1'b0;
            rbuf.wr  <= 1'b0;
            rbuf.suc <= 1'b0;
            rbuf.addr[dcache_pkg::offset_width +: index_width] <= '0;
        end else if (load) begin
            rbuf.op   <= req_op;
            rbuf.wr   <= req_wr;
            rbuf.suc  <= req_suc;
            rbuf.addr <= req_addr;
        end
    end

    // payload
    always_ff @(posedge clk) begin
        if (load) begin
            rbuf.opcode <= req_opcode;
            rbuf.wstrb  <= req_wstrb;
            rbuf.wdata  <= req_wdata;
        end
    end

    // uncached read always goes to memory, buffer must hold through it
    assert property (@(posedge clk) disable iff (!rstn)
        load && req_suc && !req_wr && !req_op |=> !load [*2]);

endmodule

/* verilog/dcache_if.sv */
`timescale 1ns/10ps

// request as held by the request buffer
interface rbuf_if;
    dcache_pkg::addr_t     addr;
    logic                  wr;
    logic                  suc;
    logic                  op;
    dcache_pkg::cache_op_t opcode;
    dcache_pkg::wstrb_t    wstrb;
    dcache_pkg::word_t     wdata;

    modport source (output addr, wr, suc, op, opcode, wstrb, wdata);
    modport sink   (input  addr, wr, suc, op, opcode, wstrb, wdata);
endinterface

// array commands from the controller, hit and victim back
interface array_if;
    dcache_pkg::way_vec_t data_we;
    dcache_pkg::way_vec_t tagv_unvalid;
    dcache_pkg::way_vec_t tagv_init;
    logic                 refill;
    logic                 choose_way;
    logic                 choose_return;
    logic                 use0;
    logic                 use1;
    dcache_pkg::way_vec_t hit;
    logic                 victim;

    modport ctrl (
        output data_we, tagv_unvalid, tagv_init, refill,
        output choose_way, choose_return, use0, use1,
        input  hit, victim
    );
    modport array (
        input  data_we, tagv_unvalid, tagv_init, refill,
        input  choose_way, choose_return, use0, use1,
        output hit, victim
    );
endinterface

/* verilog/dcache_pkg.sv */
package dcache_pkg;

    // byte offset inside the one-word line
    localparam int offset_width = 2;

    typedef logic [31:0] addr_t;
    typedef logic [31:0] word_t;
    typedef logic [3:0]  wstrb_t;

    // one bit per way, used for hit and per-way command masks
    typedef logic [1:0]  way_vec_t;

    // maintenance op codes
    typedef logic [1:0]  cache_op_t;
    localparam cache_op_t op_index_init = 2'd0;
    localparam cache_op_t op_index_inv  = 2'd1;
    localparam cache_op_t op_hit_inv    = 2'd2;

    typedef enum logic [2:0] {
        st_idle,
        st_lookup,
        st_operation,
        st_miss_read,
        st_miss_wait,
        st_miss_done,
        st_miss_write,
        st_hit_write
    } ctrl_state_t;

endpackage
